// File: list.f
+incdir+common
common/mmio_pkg.sv
common/boot_ram_pkg.sv
boot_ram/boot_ram_lane_align.sv
boot_ram/boot_ram_line_store.sv
boot_ram/boot_ram_lane_select.sv
boot_ram/boot_ram_top.sv
tb/boot_ram_asserts.sv
tb/boot_ram_tb.sv

// File: Makefile
# Verilator build and run of the boot RAM testbench

.PHONY: all lint clean

all: sim.log
	grep -q "^Done: no errors$$" sim.log

sim.log: obj_dir/boot_ram_sim
	./obj_dir/boot_ram_sim > sim.log 2>&1; cat sim.log

obj_dir/boot_ram_sim: list.f common/*.sv common/*.svh boot_ram/*.sv tb/*.sv
	verilator --binary --timing --assert -f list.f --top-module boot_ram_tb -o boot_ram_sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module boot_ram_tb

clean:
	rm -rf obj_dir sim.log

// File: tb/boot_ram_tb.sv
// testbench boot_ram_tb with clock, reset, stimulus, reference model and response checks
`timescale 1ns/1ps

module boot_ram_tb
   import mmio_pkg::*;
();

   localparam int POOL_SIZE  = 32;    // prefilled word addresses for the random mix
   localparam int RANDOM_OPS = 400;
   localparam int DRAIN_MAX  = 50;    // cycles allowed for outstanding responses

   logic      i_etx_clk;
   logic      i_reset;
   mmio_req_t req;
   mmio_rsp_t rsp;

   integer errors   = 0;
   integer timeouts = 0;
   integer seed     = 32'h351b;
   integer cycle    = 0;   // negedge count

   logic [7:0] ref_mem [0:65535];   // byte image of the RAM
   mmio_data_t exp_q [$];
   string      name_q [$];
   int         issue_q [$];         // negedge count at which each access was driven
   mmio_addr_t pool [POOL_SIZE];

   boot_ram_top dut_i (
      .i_etx_clk ( i_etx_clk ),
      .i_reset   ( i_reset   ),
      .i_req     ( req       ),
      .o_rsp     ( rsp       )
   );

   initial begin
      i_etx_clk = 1'b0;
      forever #5 i_etx_clk = ~i_etx_clk;
   end

   ////////////////////////////////////////
   // reference model

   // write first and then read the addressed word
   function automatic mmio_data_t ref_access(input mmio_addr_t addr, input mmio_strb_t strb,
                                             input mmio_data_t wdata);
      mmio_data_t word;
      mmio_addr_t a;
      int         i;
      for (i = 0; i < 8; i++) begin
         a = {addr[15:3], i[2:0]};   // byte offset bits of addr ignored
         if (strb[i]) begin
            ref_mem[a] = wdata[i*8 +: 8];
         end
         word[i*8 +: 8] = ref_mem[a];
      end
      return word;
   endfunction

   ////////////////////////////////////////
   // response checks

   task automatic check_response;
      mmio_data_t exp;
      string      name;
      int         issued;
      exp    = exp_q.pop_front();
      name   = name_q.pop_front();
      issued = issue_q.pop_front();
      if (rsp.rdata !== exp) begin
         errors++;
         $display("Error %s: expected %h, actual %h", name, exp, rsp.rdata);
      end
      if (cycle - issued != 3) begin
         errors++;
         $display("Error %s latency: expected 3, actual %0d", name, cycle - issued);
      end
   endtask

   always @(negedge i_etx_clk) begin
      cycle = cycle + 1;
      if (i_reset) begin
         if (rsp.valid) begin
            errors++;
            $display("o_rsp.valid went high during reset");
         end
      end else begin
         if (rsp.valid) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("a response arrived with no access outstanding");
            end else begin
               check_response();
            end
         end
         if (req.en) begin
            issue_q.push_back(cycle);
         end
      end
   end

   ////////////////////////////////////////
   // stimulus tasks

   task automatic issue(input mmio_addr_t addr, input mmio_strb_t strb,
                        input mmio_data_t wdata, input string name);
      @(posedge i_etx_clk);
      req.en    <= 1'b1;
      req.strb  <= strb;
      req.addr  <= addr;
      req.wdata <= wdata;
      exp_q.push_back(ref_access(addr, strb, wdata));
      name_q.push_back(name);
   endtask

   task automatic idle;
      @(posedge i_etx_clk);
      req.en <= 1'b0;
   endtask

   task automatic drain;
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
         @(posedge i_etx_clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         timeouts++;
         $display("timeout: %0d responses never arrived", exp_q.size());
         exp_q.delete();
         name_q.delete();
         issue_q.delete();
      end
   endtask

   task automatic lane_tests;
      issue(16'h0100, 8'hff, 64'h0123_4567_89ab_cdef, "lane_write");
      issue(16'h0108, 8'hff, 64'hfedc_ba98_7654_3210, "lane_write");
      idle();
      issue(16'h0100, 8'h00, 64'h0, "lane_read");
      issue(16'h0108, 8'h00, 64'h0, "lane_read");
      issue(16'h0108, 8'hff, 64'h5a5a_a5a5_3c3c_c3c3, "lane_write");
      issue(16'h0100, 8'h00, 64'h0, "lane_keep");   // lane 0 untouched by lane 1
      issue(16'h010d, 8'h00, 64'h0, "lane_read");
      idle();
      drain();
   endtask

   task automatic partial_tests;
      mmio_strb_t  masks [4] = '{8'h0f, 8'ha5, 8'h80, 8'h01};
      logic [31:0] hi;
      logic [31:0] lo;
      int          k;
      for (k = 0; k < 4; k++) begin
         hi = $random(seed);
         lo = $random(seed);
         issue(16'h0108, masks[k], {hi, lo}, "partial_write");
         issue(16'h0108, 8'h00, 64'h0, "partial_read");
         issue(16'h0100, 8'h00, 64'h0, "partial_other_lane");
      end
      idle();
      drain();
   endtask

   // same line on every cycle so each access sees the writes before it
   task automatic back_to_back_tests;
      issue(16'h0200, 8'hff, 64'h1111_2222_3333_4444, "back_to_back");
      issue(16'h0208, 8'hff, 64'h5555_6666_7777_8888, "back_to_back");
      issue(16'h0200, 8'h00, 64'h0, "back_to_back");
      issue(16'h0200, 8'h3c, 64'h9999_aaaa_bbbb_cccc, "back_to_back");
      issue(16'h0200, 8'h00, 64'h0, "back_to_back");
      issue(16'h0208, 8'h00, 64'h0, "back_to_back");
      issue(16'h0208, 8'h01, 64'hdddd_eeee_ffff_0000, "back_to_back");
      issue(16'h0208, 8'h00, 64'h0, "back_to_back");
      idle();
      drain();
   endtask

   task automatic random_tests;
      logic [31:0] rnd;
      logic [31:0] hi;
      logic [31:0] lo;
      mmio_addr_t  addr;
      mmio_strb_t  strb;
      int          k;
      for (k = 0; k < POOL_SIZE; k++) begin
         rnd     = $random(seed);
         pool[k] = {rnd[15:3], 3'b000};
         hi      = $random(seed);
         lo      = $random(seed);
         issue(pool[k], 8'hff, {hi, lo}, "prefill");
      end
      for (k = 0; k < RANDOM_OPS; k++) begin
         rnd  = $random(seed);
         addr = pool[rnd[4:0]] | {13'd0, rnd[10:8]};   // low offset bits vary
         strb = rnd[11] ? rnd[23:16] : 8'h00;          // about half reads
         hi   = $random(seed);
         lo   = $random(seed);
         issue(addr, strb, {hi, lo}, "random");
         if (rnd[31:29] == 3'd0) begin
            idle();   // occasional gap
         end
      end
      idle();
      drain();
   endtask

   task automatic finish_run;
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   ////////////////////////////////////////
   // main sequence

   initial begin
      i_reset = 1'b1;
      req     = '0;
      repeat (2) @(posedge i_etx_clk);
      req.en <= 1'b1;   // reads that the reset has to swallow
      repeat (4) @(posedge i_etx_clk);
      req.en <= 1'b0;   // quiet for the last reset cycles
      repeat (4) @(posedge i_etx_clk);
      i_reset <= 1'b0;

      // idle port after reset
      repeat (8) begin
         @(negedge i_etx_clk);
         if (rsp.valid) begin
            errors++;
            $display("o_rsp.valid went high after reset with no access");
         end
      end

      lane_tests();
      partial_tests();
      back_to_back_tests();
      random_tests();
      finish_run();
   end

endmodule

// File: tb/boot_ram_asserts.sv
// module boot_ram_asserts with reset, latency and data checks on the boot RAM port, and its bind
`timescale 1ns/1ps

module boot_ram_asserts
   import mmio_pkg::*;
(
   input logic      i_etx_clk,
   input logic      i_reset,
   input mmio_req_t i_req,
   input mmio_rsp_t o_rsp
);

   ////////////////////////////////////////
   // reset

   // valid cleared by the first reset edge
   reset_clears_valid: assert property (
      @(posedge i_etx_clk) i_reset |=> !o_rsp.valid
   ) else $error("o_rsp.valid high while in reset");

   ////////////////////////////////////////
   // pipeline

   // one response per access, three stages later
   valid_latency: assert property (
      @(posedge i_etx_clk) disable iff (i_reset)
      o_rsp.valid == $past(i_req.en, 3)
   ) else $error("o_rsp.valid does not follow i_req.en by three cycles");

   rdata_known: assert property (
      @(posedge i_etx_clk) disable iff (i_reset)
      o_rsp.valid |-> !$isunknown(o_rsp.rdata)
   ) else $error("o_rsp.rdata has unknown bits while o_rsp.valid is high");

endmodule

bind boot_ram_top boot_ram_asserts asserts_i (.*);

// File: boot_ram/boot_ram_top.sv
// module boot_ram_top chaining the align, store and select stages of the boot RAM
`timescale 1ns/1ps

module boot_ram_top
   import mmio_pkg::*, boot_ram_pkg::*;
(
   input  logic      i_etx_clk,
   input  logic      i_reset,
   input  mmio_req_t i_req,
   output mmio_rsp_t o_rsp
);

   ////////////////////////////////////////
   // stage links

   line_req_t align_line_req;   // stage 1 to stage 2
   line_rsp_t store_line_rsp;   // stage 2 to stage 3

   ////////////////////////////////////////
   // pipeline

   boot_ram_lane_align lane_align_i (
      .i_etx_clk  ( i_etx_clk      ),
      .i_reset    ( i_reset        ),
      .i_req      ( i_req          ),
      .o_line_req ( align_line_req )
   );

   boot_ram_line_store line_store_i (
      .i_etx_clk  ( i_etx_clk      ),
      .i_reset    ( i_reset        ),
      .i_line_req ( align_line_req ),
      .o_line_rsp ( store_line_rsp )
   );

   boot_ram_lane_select lane_select_i (
      .i_etx_clk  ( i_etx_clk      ),
      .i_reset    ( i_reset        ),
      .i_line_rsp ( store_line_rsp ),
      .o_rsp      ( o_rsp          )
   );

endmodule

// File: boot_ram/boot_ram_lane_select.sv
// module boot_ram_lane_select for picking the port word out of the read line
`timescale 1ns/1ps

module boot_ram_lane_select
   import mmio_pkg::*, boot_ram_pkg::*;
(
   input  logic      i_etx_clk,
   input  logic      i_reset,
   input  line_rsp_t i_line_rsp,
   output mmio_rsp_t o_rsp
);

   mmio_data_t lane_data;   // addressed word of the line

   logic       valid_q;
   mmio_data_t rdata_q;

   ////////////////////////////////////////
   // lane select

   // shift down by one port width per lane step
   assign lane_data = mmio_data_t'(i_line_rsp.rdata >> (MMIO_DATA_W * i_line_rsp.lane));

   ////////////////////////////////////////
   // stage 3 register

   always_ff @(posedge i_etx_clk) begin
      if (i_reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_line_rsp.valid;
      end
   end

   always_ff @(posedge i_etx_clk) begin
      if (i_line_rsp.valid) begin
         rdata_q <= lane_data;
      end
   end

   assign o_rsp.valid = valid_q;
   assign o_rsp.rdata = rdata_q;   // held between responses

endmodule

// File: boot_ram/boot_ram_line_store.sv
// module boot_ram_line_store with the line array and its write-first line read
`timescale 1ns/1ps

module boot_ram_line_store
   import boot_ram_pkg::*;
(
   input  logic      i_etx_clk,
   input  logic      i_reset,
   input  line_req_t i_line_req,
   output line_rsp_t o_line_rsp
);

   ////////////////////////////////////////
   // storage

   line_data_t mem [NUM_LINES];   // no preload, contents unknown at start

   line_data_t old_line;          // line before this access
   line_data_t merged_line;       // line after this access

   logic       valid_q;
   lane_idx_t  lane_q;
   line_data_t rdata_q;

   assign old_line = mem[i_line_req.line];

   // write-first view of the line
   always_comb begin
      merged_line = old_line;
      for (int b = 0; b < LINE_STRB_W; b++) begin
         if (i_line_req.strb[b]) begin
            merged_line[b*8 +: 8] = i_line_req.wdata[b*8 +: 8];
         end
      end
   end

   ////////////////////////////////////////
   // array write

   // per-byte enables keep the untouched bytes as they were
   always_ff @(posedge i_etx_clk) begin
      if (i_line_req.en) begin
         for (int b = 0; b < LINE_STRB_W; b++) begin
            if (i_line_req.strb[b]) begin
               mem[i_line_req.line][b*8 +: 8] <= i_line_req.wdata[b*8 +: 8];
            end
         end
      end
   end

   ////////////////////////////////////////
   // stage 2 register

   always_ff @(posedge i_etx_clk) begin
      if (i_reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_line_req.en;   // writes answer too
      end
   end

   always_ff @(posedge i_etx_clk) begin
      if (i_line_req.en) begin
         lane_q  <= i_line_req.lane;
         rdata_q <= merged_line;
      end
   end

   assign o_line_rsp.valid = valid_q;
   assign o_line_rsp.lane  = lane_q;
   assign o_line_rsp.rdata = rdata_q;

endmodule

// File: boot_ram/boot_ram_lane_align.sv
// module boot_ram_lane_align for address decode and line alignment of a port request
`timescale 1ns/1ps

module boot_ram_lane_align
   import mmio_pkg::*, boot_ram_pkg::*;
(
   input  logic      i_etx_clk,
   input  logic      i_reset,
   input  mmio_req_t i_req,
   output line_req_t o_line_req
);

   ////////////////////////////////////////
   // decode

   line_idx_t  line_d;
   lane_idx_t  lane_d;
   line_strb_t strb_d;
   line_data_t wdata_d;

   // stage registers
   logic       en_q;
   line_idx_t  line_q;
   lane_idx_t  lane_q;
   line_strb_t strb_q;
   line_data_t wdata_q;

   // low offset bits dropped here
   assign lane_d = i_req.addr[MMIO_OFFSET_W +: LANE_IDX_W];
   assign line_d = i_req.addr[MMIO_OFFSET_W + LANE_IDX_W +: LINE_IDX_W];

   // byte mask moved into the addressed half of the line
   assign strb_d = line_strb_t'(i_req.strb) << (MMIO_STRB_W * lane_d);

   // same word in every lane, the mask picks the right one
   assign wdata_d = {LANES{i_req.wdata}};

   ////////////////////////////////////////
   // stage 1 register

   always_ff @(posedge i_etx_clk) begin
      if (i_reset) begin
         en_q <= 1'b0;
      end else begin
         en_q <= i_req.en;
      end
   end

   always_ff @(posedge i_etx_clk) begin
      if (i_req.en) begin   // payload only moves with an access
         line_q  <= line_d;
         lane_q  <= lane_d;
         strb_q  <= strb_d;
         wdata_q <= wdata_d;
      end
   end

   assign o_line_req.en    = en_q;
   assign o_line_req.line  = line_q;
   assign o_line_req.lane  = lane_q;
   assign o_line_req.strb  = strb_q;
   assign o_line_req.wdata = wdata_q;

endmodule

// File: common/boot_ram_pkg.sv
// package boot_ram_pkg with the line organization types of the storage
`include "boot_ram_params.svh"

package boot_ram_pkg;

   ////////////////////////////////////////
   // line geometry

   localparam int LINE_DATA_W = `BOOT_RAM_LINE_WIDTH;
   localparam int LINE_STRB_W = LINE_DATA_W / 8;
   localparam int LANES       = LINE_DATA_W / `BOOT_RAM_PORT_WIDTH;   // port words per line
   localparam int LANE_IDX_W  = $clog2(LANES);
   localparam int LINE_IDX_W  = `BOOT_RAM_SIZE_LOG2 - $clog2(LINE_STRB_W);
   localparam int NUM_LINES   = 2 ** LINE_IDX_W;

   typedef logic [LINE_IDX_W-1:0]  line_idx_t;
   typedef logic [LANE_IDX_W-1:0]  lane_idx_t;
   typedef logic [LINE_DATA_W-1:0] line_data_t;
   typedef logic [LINE_STRB_W-1:0] line_strb_t;

   // request already aligned to the full line
   typedef struct packed {
      logic       en;
      line_idx_t  line;
      lane_idx_t  lane;
      line_strb_t strb;
      line_data_t wdata;
   } line_req_t;

   // lane travels along so the last stage can pick the word
   typedef struct packed {
      logic       valid;
      lane_idx_t  lane;
      line_data_t rdata;
   } line_rsp_t;

endpackage

// File: common/mmio_pkg.sv
// package mmio_pkg with the access port request and response types
`include "boot_ram_params.svh"

package mmio_pkg;

   ////////////////////////////////////////
   // port geometry

   localparam int MMIO_ADDR_W   = `BOOT_RAM_SIZE_LOG2;   // byte address
   localparam int MMIO_DATA_W   = `BOOT_RAM_PORT_WIDTH;
   localparam int MMIO_STRB_W   = MMIO_DATA_W / 8;       // one bit per byte
   localparam int MMIO_OFFSET_W = $clog2(MMIO_STRB_W);   // byte offset inside a word

   typedef logic [MMIO_ADDR_W-1:0] mmio_addr_t;
   typedef logic [MMIO_DATA_W-1:0] mmio_data_t;
   typedef logic [MMIO_STRB_W-1:0] mmio_strb_t;

   ////////////////////////////////////////
   // request and response

   // strb of zero means a read
   typedef struct packed {
      logic       en;
      mmio_strb_t strb;
      mmio_addr_t addr;
      mmio_data_t wdata;
   } mmio_req_t;

   typedef struct packed {
      logic       valid;
      mmio_data_t rdata;
   } mmio_rsp_t;

endpackage

// File: common/boot_ram_params.svh
// size defines for the boot RAM capacity and its line and port widths
`ifndef BOOT_RAM_PARAMS_SVH
`define BOOT_RAM_PARAMS_SVH

// capacity in bytes as a power of two
`define BOOT_RAM_SIZE_LOG2 16

// storage line width in bits
`define BOOT_RAM_LINE_WIDTH 128

// access port width in bits
`define BOOT_RAM_PORT_WIDTH 64

`endif
